// File: hw/tile_pkg.sv
/*
 * shared bus types and constants of the memory tile
 */
`default_nettype none

package tile_pkg;

    // low address bits below the word index
    localparam int BYTE_OFFSET_W = 2;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;

    // bit n enables byte n of the word
    typedef logic [3:0] be_t;

    // request payload held with req until ack
    typedef struct packed {
        logic  we;
        addr_t addr;
        be_t   be;
        data_t wdata;
    } mem_req_t;

endpackage

`default_nettype wire

// File: hw/bus_splitter.sv
/*
 * one master to two slaves, chosen by a single address bit,
 * with in-order return of read responses
 */
`default_nettype none

module bus_splitter
    import tile_pkg::*;
#(
    parameter int BITSEL     = 31
    , parameter int PEND_DEPTH = 4
)
(
    input  wire       clk_i
    , input  wire       arst_n_i

    , input  wire       m_req_i
    , input  wire mem_req_t m_wr_i
    , output logic      m_ack_o
    , output logic      m_resp_o
    , output data_t     m_rdata_o

    , output logic      s0_req_o
    , output mem_req_t  s0_wr_o
    , input  wire       s0_ack_i
    , input  wire       s0_resp_i
    , input  wire data_t s0_rdata_i

    , output logic      s1_req_o
    , output mem_req_t  s1_wr_o
    , input  wire       s1_ack_i
    , input  wire       s1_resp_i
    , input  wire data_t s1_rdata_i
);

    localparam int PTR_W = (PEND_DEPTH > 1) ? $clog2(PEND_DEPTH) : 1;
    localparam int CNT_W = $clog2(PEND_DEPTH + 1);

    logic             tgt_q [PEND_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] cnt;
    logic             sel;
    logic             head;
    logic             full;
    logic             blocked;
    logic             fwd;
    logic             push;
    logic             pop;

    assign sel  = m_wr_i.addr[BITSEL];
    assign head = tgt_q[rd_ptr];
    assign full = (cnt == CNT_W'(PEND_DEPTH));

    // a read to the other slave waits for older reads to drain,
    // otherwise a fast slave could overtake a slow one
    assign blocked = !m_wr_i.we && (cnt > CNT_W'(pop)) && (sel != head);

    assign fwd      = m_req_i && !full && !blocked;
    assign s0_req_o = fwd && !sel;
    assign s1_req_o = fwd && sel;
    assign s0_wr_o  = m_wr_i;
    assign s1_wr_o  = m_wr_i;
    assign m_ack_o  = sel ? (s1_req_o && s1_ack_i) : (s0_req_o && s0_ack_i);

    assign m_resp_o  = head ? s1_resp_i : s0_resp_i;
    assign m_rdata_o = head ? s1_rdata_i : s0_rdata_i;

    assign push = m_ack_o && !m_wr_i.we;
    assign pop  = m_resp_o;

    always_ff @(posedge clk_i or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            cnt    <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= (wr_ptr == PTR_W'(PEND_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PTR_W'(PEND_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            cnt <= cnt + CNT_W'(push) - CNT_W'(pop);
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (push)
            tgt_q[wr_ptr] <= sel;
    end

endmodule

`default_nettype wire

// File: hw/bus_arbiter.sv
/*
 * two masters to one slave, round-robin grant,
 * responses steered back in acceptance order
 */
`default_nettype none

module bus_arbiter
    import tile_pkg::*;
#(
    parameter int PEND_DEPTH = 4
)
(
    input  wire       clk_i
    , input  wire       arst_n_i

    , input  wire       m0_req_i
    , input  wire mem_req_t m0_wr_i
    , output logic      m0_ack_o
    , output logic      m0_resp_o
    , output data_t     m0_rdata_o

    , input  wire       m1_req_i
    , input  wire mem_req_t m1_wr_i
    , output logic      m1_ack_o
    , output logic      m1_resp_o
    , output data_t     m1_rdata_o

    , output logic      s_req_o
    , output mem_req_t  s_wr_o
    , input  wire       s_ack_i
    , input  wire       s_resp_i
    , input  wire data_t s_rdata_i
);

    localparam int PTR_W = (PEND_DEPTH > 1) ? $clog2(PEND_DEPTH) : 1;
    localparam int CNT_W = $clog2(PEND_DEPTH + 1);

    logic             own_q [PEND_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] cnt;
    logic             prio;
    logic             lock_vld;
    logic             lock_gnt;
    logic             rr_gnt;
    logic             gnt;
    logic             head;
    logic             full;
    logic             accept;
    logic             push;
    logic             pop;

    // prio names the master that wins a tie
    assign rr_gnt = m1_req_i && (!m0_req_i || prio);

    // keep the grant on a request that is waiting for ack
    assign gnt = lock_vld ? lock_gnt : rr_gnt;

    assign full    = (cnt == CNT_W'(PEND_DEPTH));
    assign s_req_o = (m0_req_i || m1_req_i) && !full;
    assign s_wr_o  = gnt ? m1_wr_i : m0_wr_i;
    assign accept  = s_req_o && s_ack_i;

    assign m0_ack_o = accept && !gnt;
    assign m1_ack_o = accept && gnt;

    assign head       = own_q[rd_ptr];
    assign m0_resp_o  = s_resp_i && !head;
    assign m1_resp_o  = s_resp_i && head;
    assign m0_rdata_o = s_rdata_i;
    assign m1_rdata_o = s_rdata_i;

    assign push = accept && !s_wr_o.we;
    assign pop  = s_resp_i;

    always_ff @(posedge clk_i or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            prio     <= 1'b0;
            lock_vld <= 1'b0;
            lock_gnt <= 1'b0;
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            cnt      <= '0;
        end
        else
        begin
            if (accept)
                prio <= !gnt;
            lock_vld <= s_req_o && !s_ack_i;
            lock_gnt <= gnt;
            if (push)
                wr_ptr <= (wr_ptr == PTR_W'(PEND_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PTR_W'(PEND_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            cnt <= cnt + CNT_W'(push) - CNT_W'(pop);
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (push)
            own_q[wr_ptr] <= gnt;
    end

endmodule

`default_nettype wire

// File: hw/dual_port_ram.sv
/*
 * word RAM, read-only fetch port and byte-enabled data port
 */
`default_nettype none

module dual_port_ram
    import tile_pkg::*;
#(
    parameter int MEM_WORDS = 1024
)
(
    input  wire       clk_i
    , input  wire       arst_n_i

    , input  wire       f_req_i
    , input  wire addr_t f_addr_i
    , output logic      f_ack_o
    , output logic      f_resp_o
    , output data_t     f_rdata_o

    , input  wire       d_req_i
    , input  wire mem_req_t d_wr_i
    , output logic      d_ack_o
    , output logic      d_resp_o
    , output data_t     d_rdata_o
);

    localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

    data_t            mem [MEM_WORDS];
    logic [IDX_W-1:0] f_idx;
    logic [IDX_W-1:0] d_idx;

    // word index wraps at MEM_WORDS
    assign f_idx = IDX_W'((f_addr_i >> BYTE_OFFSET_W) % MEM_WORDS);
    assign d_idx = IDX_W'((d_wr_i.addr >> BYTE_OFFSET_W) % MEM_WORDS);

    assign f_ack_o = f_req_i;
    assign d_ack_o = d_req_i;

    always_ff @(posedge clk_i or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            f_resp_o <= 1'b0;
            d_resp_o <= 1'b0;
        end
        else
        begin
            f_resp_o <= f_req_i;
            d_resp_o <= d_req_i && !d_wr_i.we;
        end
    end

    // fetch sees the word as it was before a same-cycle write
    always_ff @(posedge clk_i)
    begin
        if (f_req_i)
            f_rdata_o <= mem[f_idx];
        if (d_req_i && !d_wr_i.we)
            d_rdata_o <= mem[d_idx];
        if (d_req_i && d_wr_i.we)
        begin
            for (int b = 0; b < 4; b++)
            begin
                if (d_wr_i.be[b])
                    mem[d_idx][8*b +: 8] <= d_wr_i.wdata[8*b +: 8];
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/sfr_block.sv
/*
 * special-function registers holding the core id and three scratch words
 */
`default_nettype none

module sfr_block
    import tile_pkg::*;
#(
    parameter int CORE_NUM = 0
)
(
    input  wire       clk_i
    , input  wire       arst_n_i

    , input  wire       req_i
    , input  wire mem_req_t wr_i
    , output logic      ack_o
    , output logic      resp_o
    , output data_t     rdata_o
);

    data_t      scratch [1:3];
    logic [1:0] word;

    // only bits 3:2 decoded so higher offsets alias
    assign word  = wr_i.addr[3:2];
    assign ack_o = req_i;

    always_ff @(posedge clk_i or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            resp_o     <= 1'b0;
            scratch[1] <= '0;
            scratch[2] <= '0;
            scratch[3] <= '0;
        end
        else
        begin
            resp_o <= req_i && !wr_i.we;
            // word 0 is read only
            if (req_i && wr_i.we && (word != 2'd0))
            begin
                for (int b = 0; b < 4; b++)
                begin
                    if (wr_i.be[b])
                        scratch[word][8*b +: 8] <= wr_i.wdata[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (req_i && !wr_i.we)
            rdata_o <= (word == 2'd0) ? data_t'(CORE_NUM) : scratch[word];
    end

endmodule

`default_nettype wire

// File: hw/sigma_tile.sv
/*
 * memory tile top with the core data split to xbus, core and host arbitration,
 * RAM and SFR split and instruction fetch from the RAM second port
 */
`default_nettype none

module sigma_tile
    import tile_pkg::*;
#(
    parameter int CORE_NUM      = 0
    , parameter int MEM_WORDS   = 1024
    , parameter int XBUS_BITSEL = 31
    , parameter int SFR_BITSEL  = 20
    , parameter int PEND_DEPTH  = 4
)
(
    input  wire       clk_i
    , input  wire       arst_n_i

    , input  wire       instr_req_i
    , input  wire addr_t instr_addr_i
    , output logic      instr_ack_o
    , output logic      instr_resp_o
    , output data_t     instr_rdata_o

    , input  wire       cpu_req_i
    , input  wire mem_req_t cpu_wr_i
    , output logic      cpu_ack_o
    , output logic      cpu_resp_o
    , output data_t     cpu_rdata_o

    , input  wire       hpi_req_i
    , input  wire mem_req_t hpi_wr_i
    , output logic      hpi_ack_o
    , output logic      hpi_resp_o
    , output data_t     hpi_rdata_o

    , output logic      xbus_req_o
    , output mem_req_t  xbus_wr_o
    , input  wire       xbus_ack_i
    , input  wire       xbus_resp_i
    , input  wire data_t xbus_rdata_i
);

    // core data toward the internal arbiter
    logic     cpu_int_req;
    logic     cpu_int_ack;
    logic     cpu_int_resp;
    mem_req_t cpu_int_wr;
    data_t    cpu_int_rdata;

    // arbitrated internal path
    logic     l2_req;
    logic     l2_ack;
    logic     l2_resp;
    mem_req_t l2_wr;
    data_t    l2_rdata;

    logic     dmem_req;
    logic     dmem_ack;
    logic     dmem_resp;
    mem_req_t dmem_wr;
    data_t    dmem_rdata;

    logic     sfr_req;
    logic     sfr_ack;
    logic     sfr_resp;
    mem_req_t sfr_wr;
    data_t    sfr_rdata;

    bus_splitter #(
        .BITSEL       (XBUS_BITSEL)
        , .PEND_DEPTH (PEND_DEPTH)
    ) split_cpu (
        .clk_i         (clk_i)
        , .arst_n_i    (arst_n_i)
        , .m_req_i     (cpu_req_i)
        , .m_wr_i      (cpu_wr_i)
        , .m_ack_o     (cpu_ack_o)
        , .m_resp_o    (cpu_resp_o)
        , .m_rdata_o   (cpu_rdata_o)
        , .s0_req_o    (cpu_int_req)
        , .s0_wr_o     (cpu_int_wr)
        , .s0_ack_i    (cpu_int_ack)
        , .s0_resp_i   (cpu_int_resp)
        , .s0_rdata_i  (cpu_int_rdata)
        , .s1_req_o    (xbus_req_o)
        , .s1_wr_o     (xbus_wr_o)
        , .s1_ack_i    (xbus_ack_i)
        , .s1_resp_i   (xbus_resp_i)
        , .s1_rdata_i  (xbus_rdata_i)
    );

    bus_arbiter #(
        .PEND_DEPTH (PEND_DEPTH)
    ) arb_internal (
        .clk_i         (clk_i)
        , .arst_n_i    (arst_n_i)
        , .m0_req_i    (cpu_int_req)
        , .m0_wr_i     (cpu_int_wr)
        , .m0_ack_o    (cpu_int_ack)
        , .m0_resp_o   (cpu_int_resp)
        , .m0_rdata_o  (cpu_int_rdata)
        , .m1_req_i    (hpi_req_i)
        , .m1_wr_i     (hpi_wr_i)
        , .m1_ack_o    (hpi_ack_o)
        , .m1_resp_o   (hpi_resp_o)
        , .m1_rdata_o  (hpi_rdata_o)
        , .s_req_o     (l2_req)
        , .s_wr_o      (l2_wr)
        , .s_ack_i     (l2_ack)
        , .s_resp_i    (l2_resp)
        , .s_rdata_i   (l2_rdata)
    );

    bus_splitter #(
        .BITSEL       (SFR_BITSEL)
        , .PEND_DEPTH (PEND_DEPTH)
    ) split_l2 (
        .clk_i         (clk_i)
        , .arst_n_i    (arst_n_i)
        , .m_req_i     (l2_req)
        , .m_wr_i      (l2_wr)
        , .m_ack_o     (l2_ack)
        , .m_resp_o    (l2_resp)
        , .m_rdata_o   (l2_rdata)
        , .s0_req_o    (dmem_req)
        , .s0_wr_o     (dmem_wr)
        , .s0_ack_i    (dmem_ack)
        , .s0_resp_i   (dmem_resp)
        , .s0_rdata_i  (dmem_rdata)
        , .s1_req_o    (sfr_req)
        , .s1_wr_o     (sfr_wr)
        , .s1_ack_i    (sfr_ack)
        , .s1_resp_i   (sfr_resp)
        , .s1_rdata_i  (sfr_rdata)
    );

    dual_port_ram #(
        .MEM_WORDS (MEM_WORDS)
    ) ram (
        .clk_i         (clk_i)
        , .arst_n_i    (arst_n_i)
        , .f_req_i     (instr_req_i)
        , .f_addr_i    (instr_addr_i)
        , .f_ack_o     (instr_ack_o)
        , .f_resp_o    (instr_resp_o)
        , .f_rdata_o   (instr_rdata_o)
        , .d_req_i     (dmem_req)
        , .d_wr_i      (dmem_wr)
        , .d_ack_o     (dmem_ack)
        , .d_resp_o    (dmem_resp)
        , .d_rdata_o   (dmem_rdata)
    );

    sfr_block #(
        .CORE_NUM (CORE_NUM)
    ) sfr (
        .clk_i         (clk_i)
        , .arst_n_i    (arst_n_i)
        , .req_i       (sfr_req)
        , .wr_i        (sfr_wr)
        , .ack_o       (sfr_ack)
        , .resp_o      (sfr_resp)
        , .rdata_o     (sfr_rdata)
    );

endmodule

`default_nettype wire

// File: test/tb_sigma_tile.sv
/*
 * testbench for the memory tile with random core, host and fetch traffic,
 * an external bus responder, a reference model and a watchdog
 */
`default_nettype none

module tb_sigma_tile
    import tile_pkg::*;
;

    localparam int HALF       = 20;
    localparam int CORE_NUM   = 5;
    localparam int MEM_WORDS  = 64;
    localparam int N_INIT     = 32;
    localparam int N_RAND     = 300;
    localparam int N_STRESS   = 120;
    localparam int N_PER_PORT = N_INIT + N_RAND + N_STRESS;
    localparam int N_TESTS    = 2 * N_PER_PORT;

    // bound for outstanding reads once the responder answers every cycle
    localparam int DRAIN_CYCLES = 16;

    // port ids of the expected-read queues
    localparam int P_FETCH = 0;
    localparam int P_CORE  = 1;
    localparam int P_HOST  = 2;

    logic     clk;
    logic     arst_n;
    logic     instr_req;
    addr_t    instr_addr;
    logic     instr_ack;
    logic     instr_resp;
    data_t    instr_rdata;
    logic     cpu_req;
    mem_req_t cpu_wr;
    logic     cpu_ack;
    logic     cpu_resp;
    data_t    cpu_rdata;
    logic     hpi_req;
    mem_req_t hpi_wr;
    logic     hpi_ack;
    logic     hpi_resp;
    data_t    hpi_rdata;
    logic     xbus_req;
    mem_req_t xbus_wr;
    logic     xbus_ack;
    logic     xbus_resp;
    data_t    xbus_rdata;

    integer seed = 44549;
    int     cycle;
    int     drain_cnt;
    int     cpu_issued;
    int     hpi_issued;
    int     cpu_done;
    int     hpi_done;
    logic   cpu_busy;
    logic   hpi_busy;
    logic   finished;
    logic   draining;

    // reference model state
    data_t ram_m [MEM_WORDS];
    data_t sfr_m [4];
    data_t xmem [addr_t];
    data_t xbus_pend_q [$];
    data_t exp_q [3][$];
    int    due_q [3][$];
    int    rd_acc [3];
    int    resp_cnt [3];

    sigma_tile #(
        .CORE_NUM    (CORE_NUM)
        , .MEM_WORDS (MEM_WORDS)
    ) DUT (
        .clk_i           (clk)
        , .arst_n_i      (arst_n)
        , .instr_req_i   (instr_req)
        , .instr_addr_i  (instr_addr)
        , .instr_ack_o   (instr_ack)
        , .instr_resp_o  (instr_resp)
        , .instr_rdata_o (instr_rdata)
        , .cpu_req_i     (cpu_req)
        , .cpu_wr_i      (cpu_wr)
        , .cpu_ack_o     (cpu_ack)
        , .cpu_resp_o    (cpu_resp)
        , .cpu_rdata_o   (cpu_rdata)
        , .hpi_req_i     (hpi_req)
        , .hpi_wr_i      (hpi_wr)
        , .hpi_ack_o     (hpi_ack)
        , .hpi_resp_o    (hpi_resp)
        , .hpi_rdata_o   (hpi_rdata)
        , .xbus_req_o    (xbus_req)
        , .xbus_wr_o     (xbus_wr)
        , .xbus_ack_i    (xbus_ack)
        , .xbus_resp_i   (xbus_resp)
        , .xbus_rdata_i  (xbus_rdata)
    );

    function automatic logic [31:0] next_rand();
        return $random(seed);
    endfunction

    function automatic data_t merge_bytes(input data_t old_w, input data_t new_w, input be_t be);
        data_t res;
        res = old_w;
        for (int b = 0; b < 4; b++)
        begin
            if (be[b])
                res[8*b +: 8] = new_w[8*b +: 8];
        end
        return res;
    endfunction

    function automatic int word_index(input addr_t a);
        return int'((a >> BYTE_OFFSET_W) % MEM_WORDS);
    endfunction

    // unwritten external words read back a pattern of their word address
    function automatic data_t xbus_read(input addr_t a);
        addr_t k;
        k = a >> BYTE_OFFSET_W;
        if (xmem.exists(k))
            return xmem[k];
        return k ^ {k[15:0], k[31:16]} ^ 32'h5A3C_96E1;
    endfunction

    // core words 0..31 of the RAM, or external bus
    function automatic mem_req_t core_request(input int n);
        mem_req_t q;
        logic [31:0] r;
        r = next_rand();
        q.addr  = next_rand();
        q.wdata = next_rand();
        q.we    = r[3];
        q.be    = r[7:4];
        if (n < N_INIT)
        begin
            q.addr[31]  = 1'b0;
            q.addr[20]  = 1'b0;
            q.addr[7:2] = {1'b0, n[4:0]};
            q.we        = 1'b1;
            q.be        = 4'hF;
        end
        else if (r[2:0] < 3'd3)
            q.addr = {1'b1, 23'd0, q.addr[7:0]};
        else
        begin
            q.addr[31] = 1'b0;
            q.addr[20] = 1'b0;
            q.addr[7]  = 1'b0;
        end
        return q;
    endfunction

    // host words 32..63 of the RAM, or the register block
    function automatic mem_req_t host_request(input int n);
        mem_req_t q;
        logic [31:0] r;
        r = next_rand();
        q.addr     = next_rand();
        q.wdata    = next_rand();
        q.we       = r[3];
        q.be       = r[7:4];
        q.addr[31] = 1'b0;
        if (n < N_INIT)
        begin
            q.addr[20]  = 1'b0;
            q.addr[7:2] = {1'b1, n[4:0]};
            q.we        = 1'b1;
            q.be        = 4'hF;
        end
        else if (r[1:0] == 2'b00)
            q.addr[20] = 1'b1;
        else
        begin
            q.addr[20] = 1'b0;
            q.addr[7]  = 1'b1;
        end
        return q;
    endfunction

    // requests start every cycle in init and stress phases and by coin otherwise
    function automatic logic start_request(input int issued, input logic coin);
        if (issued >= N_PER_PORT)
            return 1'b0;
        return (issued < N_INIT) || (issued >= N_INIT + N_RAND) || coin;
    endfunction

    function automatic logic reads_pending();
        return (exp_q[P_FETCH].size() != 0) || (exp_q[P_CORE].size() != 0)
            || (exp_q[P_HOST].size() != 0);
    endfunction

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_data(input string name, input data_t exp, input data_t act);
        if (act !== exp)
            stop_run($sformatf("error %s expected %h actual %h", name, exp, act));
    endtask

    task automatic check_req(input string name, input mem_req_t exp, input mem_req_t act);
        if (act !== exp)
            stop_run($sformatf("error %s expected %h actual %h", name, exp, act));
    endtask

    task automatic check_latency(input string name, input int exp, input int act);
        if (act != exp)
            stop_run($sformatf("error %s response cycle expected %0d actual %0d",
                               name, exp, act));
    endtask

    task automatic check_resp_count(input string name, input int exp, input int act);
        if (act != exp)
            stop_run($sformatf("error %s response count expected %0d actual %0d",
                               name, exp, act));
    endtask

    task automatic expect_read(input int p, input data_t d, input int due);
        exp_q[p].push_back(d);
        due_q[p].push_back(due);
        rd_acc[p]++;
    endtask

    task automatic take_response(input int p, input string name, input data_t act);
        data_t exp;
        int    due;
        if (exp_q[p].size() == 0)
            stop_run($sformatf("%s response arrived with no read outstanding", name));
        else
        begin
            exp = exp_q[p].pop_front();
            due = due_q[p].pop_front();
            resp_cnt[p]++;
            check_data(name, exp, act);
            if (due >= 0)
                check_latency(name, due, cycle);
        end
    endtask

    task automatic drive_inputs();
        logic [31:0] r;
        r = next_rand();
        if (!cpu_busy)
        begin
            cpu_req = 1'b0;
            if (start_request(cpu_issued, r[0]))
            begin
                cpu_wr   = core_request(cpu_issued);
                cpu_req  = 1'b1;
                cpu_busy = 1'b1;
                cpu_issued++;
            end
        end
        if (!hpi_busy)
        begin
            hpi_req = 1'b0;
            if (start_request(hpi_issued, r[1]))
            begin
                hpi_wr   = host_request(hpi_issued);
                hpi_req  = 1'b1;
                hpi_busy = 1'b1;
                hpi_issued++;
            end
        end
        // fetch once every RAM word holds a known value
        instr_req  = !draining && (cpu_done >= N_INIT) && (hpi_done >= N_INIT) && r[2];
        instr_addr = next_rand();
        // external responder with random ack and response delay
        xbus_ack  = (r[4:3] != 2'b00);
        xbus_resp = 1'b0;
        if (xbus_pend_q.size() > 0 && (draining || r[6:5] == 2'b00))
        begin
            xbus_resp  = 1'b1;
            xbus_rdata = xbus_pend_q.pop_front();
        end
    endtask

    task automatic sample_outputs();
        int         idx;
        logic [1:0] w;
        if (instr_resp)
            take_response(P_FETCH, "fetch read", instr_rdata);
        if (cpu_resp)
            take_response(P_CORE, "core read", cpu_rdata);
        if (hpi_resp)
            take_response(P_HOST, "host read", hpi_rdata);

        if (instr_ack !== instr_req)
            stop_run("fetch port ack does not match its request in the same cycle");

        // fetch sees RAM contents from before this edge's writes
        if (instr_req)
            expect_read(P_FETCH, ram_m[word_index(instr_addr)], cycle + 1);

        if (xbus_req)
        begin
            if (!(cpu_req && cpu_wr.addr[31]))
                stop_run("external bus request without a core request to external space");
            check_req("xbus request payload", cpu_wr, xbus_wr);
            if (xbus_ack)
            begin
                if (xbus_wr.we)
                    xmem[xbus_wr.addr >> BYTE_OFFSET_W] =
                        merge_bytes(xbus_read(xbus_wr.addr), xbus_wr.wdata, xbus_wr.be);
                else
                    xbus_pend_q.push_back(xbus_read(xbus_wr.addr));
            end
        end

        if (cpu_ack)
        begin
            if (!cpu_req)
                stop_run("core port acknowledged with no request");
            idx = word_index(cpu_wr.addr);
            if (cpu_wr.addr[31])
            begin
                if (!cpu_wr.we)
                    expect_read(P_CORE, xbus_read(cpu_wr.addr), -1);
            end
            else if (cpu_wr.we)
                ram_m[idx] = merge_bytes(ram_m[idx], cpu_wr.wdata, cpu_wr.be);
            else
                expect_read(P_CORE, ram_m[idx], cycle + 1);
            cpu_busy = 1'b0;
            cpu_done++;
        end

        if (hpi_ack)
        begin
            if (!hpi_req)
                stop_run("host port acknowledged with no request");
            idx = word_index(hpi_wr.addr);
            w   = hpi_wr.addr[3:2];
            if (hpi_wr.addr[20])
            begin
                // word 0 holds the core id
                if (hpi_wr.we && w != 2'd0)
                    sfr_m[w] = merge_bytes(sfr_m[w], hpi_wr.wdata, hpi_wr.be);
                else if (!hpi_wr.we)
                    expect_read(P_HOST, (w == 2'd0) ? data_t'(CORE_NUM) : sfr_m[w],
                                cycle + 1);
            end
            else if (hpi_wr.we)
                ram_m[idx] = merge_bytes(ram_m[idx], hpi_wr.wdata, hpi_wr.be);
            else
                expect_read(P_HOST, ram_m[idx], cycle + 1);
            hpi_busy = 1'b0;
            hpi_done++;
        end
    endtask

    task automatic run_cycle();
        @(negedge clk);
        drive_inputs();
        // sample just ahead of the rising edge
        #(HALF - 2);
        cycle++;
        sample_outputs();
    endtask

    initial
    begin
        clk = 1'b0;
        forever
            #(HALF) clk = ~clk;
    end

    initial
    begin
        repeat (N_TESTS * 64) @(posedge clk);
        stop_run("watchdog expired before all transactions completed");
    end

    initial
    begin
        arst_n     = 1'b0;
        instr_req  = 1'b0;
        instr_addr = '0;
        cpu_req    = 1'b0;
        cpu_wr     = '0;
        hpi_req    = 1'b0;
        hpi_wr     = '0;
        xbus_ack   = 1'b0;
        xbus_resp  = 1'b0;
        xbus_rdata = '0;
        cpu_busy   = 1'b0;
        hpi_busy   = 1'b0;
        finished   = 1'b0;
        draining   = 1'b0;
        cycle      = 0;
        drain_cnt  = 0;
        cpu_issued = 0;
        hpi_issued = 0;
        cpu_done   = 0;
        hpi_done   = 0;
        for (int i = 0; i < MEM_WORDS; i++)
            ram_m[i] = '0;
        for (int i = 0; i < 4; i++)
            sfr_m[i] = '0;
        for (int p = 0; p < 3; p++)
        begin
            rd_acc[p]   = 0;
            resp_cnt[p] = 0;
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        while (!finished)
        begin
            run_cycle();
            finished = (cpu_done == N_PER_PORT) && (hpi_done == N_PER_PORT);
        end

        // outstanding reads return while fetch stays idle
        draining = 1'b1;
        while (reads_pending() && drain_cnt < DRAIN_CYCLES)
        begin
            run_cycle();
            drain_cnt++;
        end

        check_resp_count("fetch", rd_acc[P_FETCH], resp_cnt[P_FETCH]);
        check_resp_count("core", rd_acc[P_CORE], resp_cnt[P_CORE]);
        check_resp_count("host", rd_acc[P_HOST], resp_cnt[P_HOST]);
        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
hw/tile_pkg.sv
hw/bus_splitter.sv
hw/bus_arbiter.sv
hw/dual_port_ram.sv
hw/sfr_block.sv
hw/sigma_tile.sv
test/tb_sigma_tile.sv

// File: Makefile
# Verilator build for the memory tile testbench

VERILATOR ?= verilator
FILELIST  ?= project.f
TB_TOP    ?= tb_sigma_tile
RTL_TOP   ?= sigma_tile
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(BUILD_DIR) -o V$(TB_TOP)
	./$(BUILD_DIR)/V$(TB_TOP)

clean:
	rm -rf $(BUILD_DIR)
